/* design/controlPkg.sv */
package controlPkg;

    // *********************************************************
    // widths and fixed constants
    localparam int instrWidth    = 16;
    localparam int addrWidth     = 16;
    localparam int regIdxWidth   = 4;
    localparam int aluModeWidth  = 4;
    localparam int irqCount      = 4;
    localparam int irqIdxWidth   = $clog2(irqCount);
    localparam int startDelay    = 40;                      // cycles spent in stepStart
    localparam int delayWidth    = $clog2(startDelay + 1);
    localparam int irqVectorBase = 20;                      // vector of line 0
    localparam int irqVectorStep = 10;

    localparam logic [regIdxWidth-1:0] spLowReg = 4'd14;    // stack pointer low byte
    localparam logic [instrWidth-1:0]  hltWord  = '1;

    // opcode fields
    localparam logic [2:0] fmtReg     = 3'b000;
    localparam logic [2:0] fmtIn      = 3'b010;
    localparam logic [2:0] fmtOut     = 3'b100;
    localparam logic [4:0] fnAluFirst = 5'b00001;
    localparam logic [4:0] fnAluLast  = 5'b01101;
    localparam logic [4:0] fnMov      = 5'b01001;           // no flag update
    localparam logic [4:0] fnStore    = 5'b01110;
    localparam logic [4:0] fnLoad     = 5'b10001;
    localparam logic [4:0] fnJmp      = 5'b10111;
    localparam logic [4:0] fnCall     = 5'b11000;
    localparam logic [4:0] fnRet      = 5'b11001;

    localparam logic [aluModeWidth-1:0] aluPassB = 4'b0000;
    localparam logic [aluModeWidth-1:0] aluPassA = 4'b1110;

    // *********************************************************
    // instruction word, one word read through several views
    typedef struct packed {
        logic [regIdxWidth-1:0] dest;
        logic [7:0]             imm;
        logic [3:0]             opcode;
    } aluImm_t;

    typedef struct packed {
        logic [regIdxWidth-1:0] dest;
        logic [regIdxWidth-1:0] src;            // source register or pair
        logic [4:0]             func;
        logic [2:0]             fmt;
    } regForm_t;

    typedef struct packed {
        logic [2:0]            cond;
        logic [instrWidth-4:0] rest;
    } branchForm_t;

    typedef union packed {
        logic [instrWidth-1:0] word;
        aluImm_t               aluImm;
        regForm_t              regForm;
        branchForm_t           branchForm;
    } instrWord_u;

    // *********************************************************
    // decode and sequencing types
    typedef enum logic [3:0] {
        opAluImm, opIn, opOut, opAluReg, opStore, opLoad,
        opJmp, opCall, opSkipWord, opRet, opHlt, opNop
    } opClass_e;

    typedef struct packed {
        opClass_e                opClass;
        logic [aluModeWidth-1:0] aluMode;
        logic [regIdxWidth-1:0]  dest;
        logic [regIdxWidth-1:0]  src;
        logic                    flagWrite;
    } decoded_t;

    // nine steps, so four bits
    typedef enum logic [3:0] {
        stepStart, stepLaunch, stepPart1, stepPart2, stepPart3,
        stepJmp, stepCall, stepIrqPush, stepIrqVector
    } step_e;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
        logic interruptEnable;
    } flags_t;

    // *********************************************************
    // datapath selects and the control word
    typedef enum logic [1:0] {regSrcAluOut = 2'b00, regSrcIoOut = 2'b10} regSrc_e;
    typedef enum logic [1:0] {aluBRegB = 2'b00, aluBImm8 = 2'b10} aluSrcB_e;
    typedef enum logic [2:0] {
        dataAluOut = 3'b000, dataPcPlusOneHigh = 3'b001, dataPcPlusOneLow = 3'b010,
        dataPcHigh = 3'b011, dataPcLow = 3'b100
    } dMemData_e;
    typedef enum logic [1:0] {addrPair = 2'b00, addrImm8 = 2'b01, addrPairPlusOne = 2'b10} dMemAddr_e;
    typedef enum logic [1:0] {statusAluFlags = 2'b00, statusDisableIrq = 2'b11} statusSrc_e;
    typedef enum logic [2:0] {
        iAddrPc = 3'b000, iAddrPcPlusOne = 3'b001, iAddrIrqVector = 3'b010,
        iAddrInstrWord = 3'b011, iAddrReturnAddr = 3'b101
    } iMemAddr_e;

    typedef struct packed {
        regSrc_e                 regFileSrc;
        logic [regIdxWidth-1:0]  regFileOutBSelect;
        logic                    regFileWriteEnable;
        logic                    regFileIncPair;
        logic                    regFileDecPair;
        aluSrcB_e                aluSrcBSelect;
        logic [aluModeWidth-1:0] aluMode;
        dMemData_e               dMemDataSelect;
        dMemAddr_e               dMemIOAddressSelect;
        logic                    dMemIOWriteEn;
        logic                    dMemIOReadEn;
        statusSrc_e              statusRegSrcSelect;
        logic                    flagEnable;
        iMemAddr_e               iMemAddrSelect;
        logic                    iMemReadEnable;
        logic                    pcWriteEn;
    } ctrlWord_t;

endpackage

/* design/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
    input  controlPkg::instrWord_u instr,
    input  controlPkg::flags_t     flags,
    output controlPkg::decoded_t   decoded
);
    import controlPkg::*;

    logic taken;                                    // branch condition holds

    // *********************************************************
    // condition codes of jmp, call and ret
    always_comb begin
        case (instr.branchForm.cond)
            3'b001:  taken = flags.carry;
            3'b010:  taken = ~flags.carry;
            3'b011:  taken = flags.zero;
            3'b100:  taken = ~flags.zero;
            3'b101:  taken = flags.negative;
            3'b110:  taken = ~flags.negative;
            default: taken = 1'b1;                  // 000 and 111 are unconditional
        endcase
    end

    // *********************************************************
    // instruction class
    always_comb begin
        decoded.opClass   = opNop;
        decoded.aluMode   = aluPassB;
        decoded.dest      = instr.regForm.dest;
        decoded.src       = instr.regForm.src;
        decoded.flagWrite = 1'b0;

        if (instr.word == hltWord) begin
            decoded.opClass = opHlt;
        end else if (instr.aluImm.opcode[0] && instr.aluImm.opcode[3:1] != 3'b111) begin
            decoded.opClass   = opAluImm;
            decoded.aluMode   = {1'b0, instr.aluImm.opcode[3:1]};
            decoded.flagWrite = (instr.aluImm.opcode[3:1] != 3'b000);  // ldi keeps flags
        end else if (instr.regForm.fmt == fmtIn) begin
            decoded.opClass = opIn;
        end else if (instr.regForm.fmt == fmtOut) begin
            decoded.opClass = opOut;
        end else if (instr.regForm.fmt == fmtReg) begin
            case (instr.regForm.func)
                fnStore: decoded.opClass = opStore;
                fnLoad:  decoded.opClass = opLoad;
                fnJmp:   decoded.opClass = taken ? opJmp : opSkipWord;
                fnCall:  decoded.opClass = taken ? opCall : opSkipWord;
                fnRet:   decoded.opClass = taken ? opRet : opNop;
                default: begin
                    if (instr.regForm.func >= fnAluFirst && instr.regForm.func <= fnAluLast) begin
                        decoded.opClass   = opAluReg;
                        decoded.aluMode   = instr.regForm.func[3:0];
                        decoded.flagWrite = (instr.regForm.func != fnMov);
                    end
                end
            endcase
        end
    end

endmodule

/* design/stepSequencer.sv */
`timescale 1ns/1ps

module stepSequencer (
    input  logic                             clk,
    input  logic                             rstN,
    input  controlPkg::decoded_t             decoded,
    input  controlPkg::flags_t               flags,
    input  logic [controlPkg::irqCount-1:0]  irqReq,
    output controlPkg::step_e                step,
    output logic [controlPkg::addrWidth-1:0] irqVector,
    output logic [controlPkg::irqCount-1:0]  irqClr
);
    import controlPkg::*;

    step_e                  stepQ;
    step_e                  stepNext;
    logic [delayWidth-1:0]  delayQ;                 // start-up wait
    logic [irqIdxWidth-1:0] irqIndex;
    logic                   irqPending;
    logic                   takeIrq;

    // *********************************************************
    // step register and start-up counter
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stepQ  <= stepStart;
            delayQ <= '0;
        end else begin
            stepQ <= stepNext;
            if (stepQ == stepStart) begin
                delayQ <= delayQ + 1'b1;
            end
        end
    end

    // *********************************************************
    // interrupt priority, line 0 wins
    always_comb begin
        irqIndex = '0;
        for (int i = irqCount - 1; i >= 0; i--) begin
            if (irqReq[i]) begin
                irqIndex = irqIdxWidth'(i);
            end
        end
    end

    assign irqPending = |irqReq;

    always_comb begin
        if (irqPending) begin
            irqVector = addrWidth'(irqVectorBase + irqVectorStep * int'(irqIndex));
        end else begin
            irqVector = '0;
        end
    end

    // entry only at an instruction boundary, never out of halt
    assign takeIrq = (stepQ == stepPart1) && flags.interruptEnable && irqPending &&
                     (decoded.opClass != opHlt);

    assign step = takeIrq ? stepIrqPush : stepQ;

    always_comb begin
        irqClr = '0;
        if (step == stepIrqVector && irqPending) begin
            irqClr = irqCount'(1) << irqIndex;      // one-hot clear
        end
    end

    // *********************************************************
    // next step
    always_comb begin
        stepNext = stepPart1;
        case (step)
            stepStart: begin
                if (delayQ == delayWidth'(startDelay - 1)) begin
                    stepNext = stepLaunch;
                end else begin
                    stepNext = stepStart;
                end
            end
            stepIrqPush: stepNext = stepIrqVector;
            stepPart1: begin
                case (decoded.opClass)
                    opLoad, opIn, opRet: stepNext = stepPart2;
                    opJmp:               stepNext = stepJmp;
                    opCall:              stepNext = stepCall;
                    default:             stepNext = stepPart1;
                endcase
            end
            stepPart2: stepNext = (decoded.opClass == opRet) ? stepPart3 : stepPart1;
            default:   stepNext = stepPart1;    // launch, jmp, call, part3, irq vector
        endcase
    end

endmodule

/* design/controlWordGen.sv */
`timescale 1ns/1ps

module controlWordGen (
    input  controlPkg::step_e     step,
    input  controlPkg::decoded_t  decoded,
    output controlPkg::ctrlWord_t ctrl
);
    import controlPkg::*;

    always_comb begin
        // quiet word, fetch held
        ctrl.regFileSrc          = regSrcAluOut;
        ctrl.regFileOutBSelect   = decoded.dest;
        ctrl.regFileWriteEnable  = 1'b0;
        ctrl.regFileIncPair      = 1'b0;
        ctrl.regFileDecPair      = 1'b0;
        ctrl.aluSrcBSelect       = aluBRegB;
        ctrl.aluMode             = aluPassB;
        ctrl.dMemDataSelect      = dataAluOut;
        ctrl.dMemIOAddressSelect = addrPair;
        ctrl.dMemIOWriteEn       = 1'b0;
        ctrl.dMemIOReadEn        = 1'b0;
        ctrl.statusRegSrcSelect  = statusAluFlags;
        ctrl.flagEnable          = 1'b0;
        ctrl.iMemAddrSelect      = iAddrPc;
        ctrl.iMemReadEnable      = 1'b0;
        ctrl.pcWriteEn           = 1'b0;

        case (step)
            // *********************************************************
            // start-up, interrupts kept off
            stepStart: begin
                ctrl.statusRegSrcSelect = statusDisableIrq;
                ctrl.flagEnable         = 1'b1;
            end
            stepLaunch: begin
                ctrl.statusRegSrcSelect = statusDisableIrq;
                ctrl.flagEnable         = 1'b1;
                ctrl.iMemReadEnable     = 1'b1;     // first fetch
                ctrl.pcWriteEn          = 1'b1;
            end

            // *********************************************************
            // first step of every instruction
            stepPart1: begin
                ctrl.iMemReadEnable = 1'b1;
                ctrl.pcWriteEn      = 1'b1;
                case (decoded.opClass)
                    opAluImm: begin
                        ctrl.regFileWriteEnable = 1'b1;
                        ctrl.aluSrcBSelect      = aluBImm8;
                        ctrl.aluMode            = decoded.aluMode;
                        ctrl.flagEnable         = decoded.flagWrite;
                    end
                    opAluReg: begin
                        ctrl.regFileOutBSelect  = decoded.src;
                        ctrl.regFileWriteEnable = 1'b1;
                        ctrl.aluMode            = decoded.aluMode;
                        ctrl.flagEnable         = decoded.flagWrite;
                    end
                    opIn: begin
                        ctrl.dMemIOAddressSelect = addrImm8;
                        ctrl.dMemIOReadEn        = 1'b1;
                        ctrl.iMemReadEnable      = 1'b0;
                        ctrl.pcWriteEn           = 1'b0;
                    end
                    opOut: begin
                        ctrl.dMemIOAddressSelect = addrImm8;
                        ctrl.dMemIOWriteEn       = 1'b1;
                    end
                    opStore: begin
                        ctrl.regFileOutBSelect = decoded.src;   // address pair
                        ctrl.aluMode           = aluPassA;
                        ctrl.dMemIOWriteEn     = 1'b1;
                    end
                    opLoad: begin
                        ctrl.regFileOutBSelect = decoded.src;
                        ctrl.dMemIOReadEn      = 1'b1;
                        ctrl.iMemReadEnable    = 1'b0;
                        ctrl.pcWriteEn         = 1'b0;
                    end
                    opCall: begin
                        ctrl.regFileOutBSelect = spLowReg;
                        ctrl.regFileDecPair    = 1'b1;
                        ctrl.dMemDataSelect    = dataPcPlusOneLow;
                        ctrl.dMemIOWriteEn     = 1'b1;
                        ctrl.pcWriteEn         = 1'b0;      // target word still to come
                    end
                    opRet: begin
                        ctrl.regFileOutBSelect   = spLowReg;
                        ctrl.regFileIncPair      = 1'b1;
                        ctrl.dMemIOAddressSelect = addrPairPlusOne;
                        ctrl.dMemIOReadEn        = 1'b1;    // return high byte
                        ctrl.iMemReadEnable      = 1'b0;
                        ctrl.pcWriteEn           = 1'b0;
                    end
                    opSkipWord: ctrl.iMemAddrSelect = iAddrPcPlusOne;
                    opHlt: begin
                        ctrl.iMemReadEnable = 1'b0;
                        ctrl.pcWriteEn      = 1'b0;
                    end
                    default: ;                      // jmp fetches its target word, nop
                endcase
            end

            // *********************************************************
            // later steps
            stepPart2: begin
                ctrl.regFileSrc = regSrcIoOut;
                case (decoded.opClass)
                    opIn: begin
                        ctrl.dMemIOAddressSelect = addrImm8;
                        ctrl.regFileWriteEnable  = 1'b1;
                        ctrl.iMemReadEnable      = 1'b1;
                        ctrl.pcWriteEn           = 1'b1;
                    end
                    opLoad: begin
                        ctrl.regFileOutBSelect  = decoded.src;
                        ctrl.regFileWriteEnable = 1'b1;
                        ctrl.iMemReadEnable     = 1'b1;
                        ctrl.pcWriteEn          = 1'b1;
                    end
                    opRet: begin
                        ctrl.regFileOutBSelect   = spLowReg;
                        ctrl.regFileIncPair      = 1'b1;
                        ctrl.dMemIOAddressSelect = addrPairPlusOne;
                        ctrl.dMemIOReadEn        = 1'b1;    // return low byte
                        ctrl.iMemAddrSelect      = iAddrReturnAddr;
                    end
                    default: ;
                endcase
            end
            stepPart3: begin
                ctrl.regFileOutBSelect = spLowReg;
                ctrl.iMemAddrSelect    = iAddrReturnAddr;
                ctrl.iMemReadEnable    = 1'b1;
                ctrl.pcWriteEn         = 1'b1;
            end
            stepJmp: begin
                ctrl.iMemAddrSelect = iAddrInstrWord;
                ctrl.iMemReadEnable = 1'b1;
                ctrl.pcWriteEn      = 1'b1;
            end
            stepCall: begin
                ctrl.regFileOutBSelect = spLowReg;
                ctrl.regFileDecPair    = 1'b1;
                ctrl.dMemDataSelect    = dataPcPlusOneHigh;
                ctrl.dMemIOWriteEn     = 1'b1;
                ctrl.iMemAddrSelect    = iAddrInstrWord;
                ctrl.iMemReadEnable    = 1'b1;
                ctrl.pcWriteEn         = 1'b1;
            end
            stepIrqPush, stepIrqVector: begin
                ctrl.regFileOutBSelect  = spLowReg;
                ctrl.regFileDecPair     = 1'b1;
                ctrl.dMemIOWriteEn      = 1'b1;
                ctrl.statusRegSrcSelect = statusDisableIrq;
                ctrl.flagEnable         = 1'b1;
                ctrl.dMemDataSelect     = (step == stepIrqPush) ? dataPcLow : dataPcHigh;
                if (step == stepIrqVector) begin
                    ctrl.iMemAddrSelect = iAddrIrqVector;
                    ctrl.iMemReadEnable = 1'b1;
                    ctrl.pcWriteEn      = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

/* design/cpuControl.sv */
`timescale 1ns/1ps

module cpuControl (
    input  logic                             clk,
    input  logic                             rstN,
    input  controlPkg::instrWord_u           instr,
    input  controlPkg::flags_t               flags,
    input  logic [controlPkg::irqCount-1:0]  irqReq,
    output controlPkg::ctrlWord_t            ctrl,
    output logic [controlPkg::addrWidth-1:0] irqVector,
    output logic [controlPkg::irqCount-1:0]  irqClr
);
    import controlPkg::*;

    decoded_t decoded;                              // class and fields of the word
    step_e    step;                                 // step presented to the generator

    instrDecode u_instrDecode (
        .instr   (instr),
        .flags   (flags),
        .decoded (decoded)
    );

    stepSequencer u_stepSequencer (
        .clk       (clk),
        .rstN      (rstN),
        .decoded   (decoded),
        .flags     (flags),
        .irqReq    (irqReq),
        .step      (step),
        .irqVector (irqVector),
        .irqClr    (irqClr)
    );

    controlWordGen u_controlWordGen (
        .step    (step),
        .decoded (decoded),
        .ctrl    (ctrl)
    );

endmodule

/* include/ctrlRefModel.svh */
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

// the seven condition codes, 000 and 111 always hold
function automatic logic refTaken(logic [2:0] cond, flags_t f);
    case (cond)
        3'd1:    return f.carry;
        3'd2:    return !f.carry;
        3'd3:    return f.zero;
        3'd4:    return !f.zero;
        3'd5:    return f.negative;
        3'd6:    return !f.negative;
        default: return 1'b1;
    endcase
endfunction

// interrupt entry replaces the first step of a non-halt instruction
function automatic step_e refPresentStep(step_e s, opClass_e cls, flags_t f,
                                         logic [irqCount-1:0] req);
    if (s == stepPart1 && f.interruptEnable && req != '0 && cls != opHlt) begin
        return stepIrqPush;
    end
    return s;
endfunction

function automatic step_e refNextStep(step_e s, opClass_e cls);
    case (s)
        stepIrqPush: return stepIrqVector;
        stepPart1: begin
            if (cls == opLoad || cls == opIn || cls == opRet) return stepPart2;
            if (cls == opJmp) return stepJmp;
            if (cls == opCall) return stepCall;
            return stepPart1;
        end
        stepPart2: return (cls == opRet) ? stepPart3 : stepPart1;
        default:   return stepPart1;
    endcase
endfunction

function automatic logic [addrWidth-1:0] refVector(logic [irqCount-1:0] req);
    for (int i = 0; i < irqCount; i++) begin
        if (req[i]) return addrWidth'(irqVectorBase + i * irqVectorStep);   // first line wins
    end
    return '0;
endfunction

function automatic logic [irqCount-1:0] refClr(step_e s, logic [irqCount-1:0] req);
    if (s != stepIrqVector) return '0;
    for (int i = 0; i < irqCount; i++) begin
        if (req[i]) return irqCount'(1) << i;
    end
    return '0;
endfunction

function automatic ctrlWord_t refCtrl(step_e s, opClass_e cls, logic [instrWidth-1:0] word,
                                      logic [aluModeWidth-1:0] mode, logic flagWrite);
    ctrlWord_t c;
    logic      fetch;
    c = '0;                                     // every select at its zero encoding
    c.regFileOutBSelect = word[15:12];          // destination field
    fetch = 1'b0;
    case (s)
        stepStart, stepLaunch: begin
            c.statusRegSrcSelect = statusDisableIrq;
            c.flagEnable         = 1'b1;
            fetch                = (s == stepLaunch);
        end
        stepPart1: begin
            fetch = !(cls inside {opIn, opLoad, opRet, opHlt});
            case (cls)
                opAluImm, opAluReg: begin
                    c.regFileWriteEnable = 1'b1;
                    c.aluMode            = mode;
                    c.flagEnable         = flagWrite;
                    if (cls == opAluImm) c.aluSrcBSelect = aluBImm8;
                    else c.regFileOutBSelect = word[11:8];
                end
                opIn, opOut: begin
                    c.dMemIOAddressSelect = addrImm8;
                    c.dMemIOReadEn        = (cls == opIn);
                    c.dMemIOWriteEn       = (cls == opOut);
                end
                opStore, opLoad: begin
                    c.regFileOutBSelect = word[11:8];  // address pair
                    c.aluMode           = (cls == opStore) ? aluPassA : aluPassB;
                    c.dMemIOWriteEn     = (cls == opStore);
                    c.dMemIOReadEn      = (cls == opLoad);
                end
                opCall: begin
                    c.regFileOutBSelect = spLowReg;
                    c.regFileDecPair    = 1'b1;
                    c.dMemDataSelect    = dataPcPlusOneLow;
                    c.dMemIOWriteEn     = 1'b1;
                end
                opRet: begin
                    c.regFileOutBSelect   = spLowReg;
                    c.regFileIncPair      = 1'b1;
                    c.dMemIOAddressSelect = addrPairPlusOne;
                    c.dMemIOReadEn        = 1'b1;
                end
                opSkipWord: c.iMemAddrSelect = iAddrPcPlusOne;
                default: ;
            endcase
        end
        stepPart2: begin
            c.regFileSrc = regSrcIoOut;
            fetch        = (cls != opRet);
            if (cls == opIn) c.dMemIOAddressSelect = addrImm8;
            if (cls == opLoad) c.regFileOutBSelect = word[11:8];
            c.regFileWriteEnable = (cls != opRet);  // read data lands in the register
            if (cls == opRet) begin
                c.regFileOutBSelect   = spLowReg;
                c.regFileIncPair      = 1'b1;
                c.dMemIOAddressSelect = addrPairPlusOne;
                c.dMemIOReadEn        = 1'b1;
                c.iMemAddrSelect      = iAddrReturnAddr;
            end
        end
        stepPart3: begin
            c.regFileOutBSelect = spLowReg;
            c.iMemAddrSelect    = iAddrReturnAddr;
            fetch               = 1'b1;
        end
        stepJmp, stepCall: begin
            c.iMemAddrSelect = iAddrInstrWord;
            fetch            = 1'b1;
            if (s == stepCall) begin
                c.regFileOutBSelect = spLowReg;
                c.regFileDecPair    = 1'b1;
                c.dMemDataSelect    = dataPcPlusOneHigh;
                c.dMemIOWriteEn     = 1'b1;
            end
        end
        default: begin                          // interrupt push and vector
            c.regFileOutBSelect  = spLowReg;
            c.regFileDecPair     = 1'b1;
            c.dMemIOWriteEn      = 1'b1;
            c.statusRegSrcSelect = statusDisableIrq;
            c.flagEnable         = 1'b1;
            c.dMemDataSelect     = (s == stepIrqPush) ? dataPcLow : dataPcHigh;
            if (s == stepIrqVector) c.iMemAddrSelect = iAddrIrqVector;
            fetch                = (s == stepIrqVector);
        end
    endcase
    c.iMemReadEnable = fetch;
    c.pcWriteEn      = fetch && !(s == stepPart1 && cls == opCall);  // call waits for target
    return c;
endfunction

`endif

/* testbench/cpuControlTb.sv */
`timescale 1ns/1ps

module cpuControlTb;
    import controlPkg::*;
    `include "ctrlRefModel.svh"

    localparam int instrCount = 600;
    localparam int cycleLimit = 5 + startDelay + 1 + instrCount * 4 + 50;   // four cycles worst case

    logic                    clk;
    logic                    rstN;
    instrWord_u              instr;
    flags_t                  flags;
    logic [irqCount-1:0]     irqReq;
    ctrlWord_t               ctrl;
    logic [addrWidth-1:0]    irqVector;
    logic [irqCount-1:0]     irqClr;

    logic [31:0]             lfsr;
    step_e                   modelStep;         // step register of the model
    step_e                   expStep;
    step_e                   expNext;
    int                      startCount;
    int                      cycleCount;
    int                      issued;
    int                      hltCycles;
    logic                    advance;           // word may change at the next edge
    opClass_e                curClass;
    logic [aluModeWidth-1:0] curMode;
    logic                    curFlagWrite;
    string                   testName;

    cpuControl u_cpuControl (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .flags     (flags),
        .irqReq    (irqReq),
        .ctrl      (ctrl),
        .irqVector (irqVector),
        .irqClr    (irqClr)
    );

    always #10 clk = ~clk;

    // *********************************************************
    // random bits, one Galois step per bit
    function automatic logic [7:0] takeBits(int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic checkCtrl(string name, ctrlWord_t expected, ctrlWord_t actual);
        if (actual !== expected) begin
            $display("error %s: expected ctrl %h, actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "control word mismatch");
        end
    endtask

    task automatic checkVector(string name, logic [addrWidth-1:0] expected,
                               logic [addrWidth-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected vector %0d, actual %0d", name, expected, actual);
            $display("Errors found");
            $fatal(1, "interrupt vector mismatch");
        end
    endtask

    task automatic checkClr(string name, logic [irqCount-1:0] expected,
                            logic [irqCount-1:0] actual);
        if (actual !== expected) begin
            $display("error %s: expected clear %b, actual %b", name, expected, actual);
            $display("Errors found");
            $fatal(1, "interrupt clear mismatch");
        end
    endtask

    // *********************************************************
    // builds one word of a chosen class with random fields
    task automatic issueInstr();
        logic [3:0]          kind;
        logic [3:0]          dest;
        logic [3:0]          src;
        logic [3:0]          mode;
        logic [7:0]          imm;
        flags_t              f;
        logic [irqCount-1:0] req;
        instrWord_u          w;
        opClass_e            cls;
        kind = 4'(takeBits(4) % 8'd11);
        dest = 4'(takeBits(4));
        src  = 4'(takeBits(4));
        imm  = takeBits(8);
        f    = flags_t'(4'(takeBits(4)));
        if (takeBits(2) == 8'd3) req = irqCount'(takeBits(4));
        else req = '0;                          // requests on about a quarter of words
        curMode      = aluPassB;
        curFlagWrite = 1'b0;
        case (kind)
            4'd0: begin
                mode         = 4'(takeBits(3) % 8'd7);
                w.word       = {dest, imm, mode[2:0], 1'b1};
                cls          = opAluImm;
                curMode      = {1'b0, mode[2:0]};
                curFlagWrite = (mode != 4'd0);  // load-immediate keeps flags
            end
            4'd1: begin
                mode         = 4'(takeBits(4) % 8'd13 + 8'd1);
                w.word       = {dest, src, 1'b0, mode, fmtReg};
                cls          = opAluReg;
                curMode      = mode;
                curFlagWrite = ({1'b0, mode} != fnMov);
            end
            4'd2: begin
                w.word = {dest, src, imm[4:0], fmtIn};
                cls    = opIn;
            end
            4'd3: begin
                w.word = {dest, src, imm[4:0], fmtOut};
                cls    = opOut;
            end
            4'd4: begin
                w.word = {dest, src, fnStore, fmtReg};
                cls    = opStore;
            end
            4'd5: begin
                w.word = {dest, src, fnLoad, fmtReg};
                cls    = opLoad;
            end
            4'd6: begin
                w.word = {dest, src, fnJmp, fmtReg};
                cls    = refTaken(dest[3:1], f) ? opJmp : opSkipWord;
            end
            4'd7: begin
                w.word = {dest, src, fnCall, fmtReg};
                cls    = refTaken(dest[3:1], f) ? opCall : opSkipWord;
            end
            4'd8: begin
                w.word = {dest, src, fnRet, fmtReg};
                cls    = refTaken(dest[3:1], f) ? opRet : opNop;
            end
            4'd9: begin
                w.word = hltWord;
                cls    = opHlt;
            end
            default: begin
                w.word = {dest, src, 8'h00};
                cls    = opNop;
            end
        endcase
        curClass = cls;
        testName = $sformatf("instr %0d %s", issued, cls.name());
        instr  <= w;
        flags  <= f;
        irqReq <= req;
        issued++;
    endtask

    initial begin
        clk          = 1'b0;
        rstN         = 1'b0;
        instr        = '0;                      // decodes as nop
        flags        = '0;
        irqReq       = '0;
        lfsr         = 32'hc517_8594;
        modelStep    = stepStart;
        startCount   = 0;
        cycleCount   = 0;
        issued       = 0;
        hltCycles    = 0;
        advance      = 1'b0;
        curClass     = opNop;
        curMode      = aluPassB;
        curFlagWrite = 1'b0;
        testName     = "start-up";
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
    end

    // *********************************************************
    // stimulus and model step register
    always @(posedge clk) begin
        if (rstN && advance) begin
            if (issued == instrCount) begin
                $display("No errors");
                $finish;
            end else begin
                issueInstr();
            end
        end
    end

    always @(posedge clk) begin
        if (!rstN) begin
            modelStep  <= stepStart;
            startCount <= 0;
        end else begin
            modelStep <= expNext;
            if (modelStep == stepStart) startCount <= startCount + 1;
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        ctrlWord_t expCtrl;
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: tests did not finish within %0d cycles", cycleLimit);
            $display("Errors found");
            $fatal(1, "timeout");
        end else begin
            expStep = refPresentStep(modelStep, curClass, flags, irqReq);
            if (modelStep == stepStart) begin
                expNext = (startCount == startDelay - 1) ? stepLaunch : stepStart;
            end else begin
                expNext = refNextStep(expStep, curClass);
            end
            expCtrl = refCtrl(expStep, curClass, instr.word, curMode, curFlagWrite);
            checkCtrl(testName, expCtrl, ctrl);
            checkVector(testName, refVector(irqReq), irqVector);
            checkClr(testName, refClr(expStep, irqReq), irqClr);
            if (expStep == stepPart1 && curClass == opHlt) hltCycles++;
            advance = expCtrl.iMemReadEnable || hltCycles == 3;   // leave halt after three cycles
            if (advance) hltCycles = 0;
        end
    end

endmodule

/* list.f */
+incdir+include
design/controlPkg.sv
design/instrDecode.sv
design/stepSequencer.sv
design/controlWordGen.sv
design/cpuControl.sv
testbench/cpuControlTb.sv

/* Makefile */
TOP := cpuControlTb

all: run

run:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -o simv
	./obj_dir/simv

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module cpuControl

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
